//--- Bender.yml
package:
  name: avmm_async_shim

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/avmm_pkg.sv
      - design/avmm_async_fifo.sv
      - design/avmm_cmd_decode.sv
      - design/avmm_mem_execute.sv
      - design/avmm_rsp_result.sv
      - design/avmm_async_shim_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/avmm_shim_chk.sv
      - testbench/avmm_shim_tb.sv

//--- design/avmm_async_fifo.sv
`timescale 1ns/10ps
// Dual-clock FIFO with Gray-coded pointers
// DEPTH must be a power of two, and a push while space is zero corrupts data
// wr_rst_n must already be synchronous to wr_clk
// rd_rst_n may come from any domain; it passes a two-flop synchronizer, resets
// the read side and leaves again on rd_rst_sync_n
// space lags read progress by the synchronizer delay, so it is pessimistic
module avmm_async_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                    wr_clk,
    input  logic                    wr_rst_n,
    input  logic [WIDTH-1:0]        wr_data,
    input  logic                    push,
    output logic [$clog2(DEPTH):0]  space,
    input  logic                    rd_clk,
    input  logic                    rd_rst_n,
    output logic                    rd_rst_sync_n,
    input  logic                    pop,
    output logic [WIDTH-1:0]        rd_data,
    output logic                    not_empty
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW:0]      wr_bin;
    logic [AW:0]      wr_bin_next;
    logic [AW:0]      wr_gray;
    logic [AW:0]      rd_bin;
    logic [AW:0]      rd_bin_next;
    logic [AW:0]      rd_gray;
    logic [AW:0]      rd_gray_s1;
    logic [AW:0]      rd_gray_s2;
    logic [AW:0]      wr_gray_s1;
    logic [AW:0]      wr_gray_s2;
    logic             rd_rst_s1;

    function automatic logic [AW:0] gray_to_bin(input logic [AW:0] g);
        logic [AW:0] b;
        b[AW] = g[AW];
        for (int i = AW - 1; i >= 0; i--)
        begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    assign wr_bin_next = wr_bin + 1'b1;
    assign rd_bin_next = rd_bin + 1'b1;

    // Storage is written on the write clock only and read without a register
    always_ff @(posedge wr_clk)
    begin
        if (push)
        begin
            mem[wr_bin[AW-1:0]] <= wr_data;
        end
    end

    // Write pointer and the read pointer as seen from the write side
    always_ff @(posedge wr_clk)
    begin
        if (!wr_rst_n)
        begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_bin  <= wr_bin_next;
                wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
            end
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    // Free entries, counted against the delayed read pointer
    assign space = (AW+1)'(DEPTH) - (wr_bin - gray_to_bin(rd_gray_s2));

    // The read side leaves reset two read clocks after the request is released
    always_ff @(posedge rd_clk)
    begin
        rd_rst_s1     <= rd_rst_n;
        rd_rst_sync_n <= rd_rst_s1;
    end

    always_ff @(posedge rd_clk)
    begin
        if (!rd_rst_sync_n)
        begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end
        else
        begin
            if (pop && not_empty)
            begin
                rd_bin  <= rd_bin_next;
                rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
            end
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    // Head entry is valid whenever the synchronized write pointer has moved on
    assign not_empty = (rd_gray != wr_gray_s2);
    assign rd_data   = mem[rd_bin[AW-1:0]];

endmodule

//--- design/avmm_async_shim_top.sv
`timescale 1ns/10ps
// Avalon clock-crossing shim with an on-chip memory in the mem_sink domain
// rst_n belongs to mem_source; the sink reset is derived inside the command FIFO
// waitrequest rises early, leaving AVMM_ALMFULL_THRESHOLD commands of margin
// Write responses are always returned, in order with read data
`include "avmm_cfg.svh"

module avmm_async_shim_top
    import avmm_pkg::*;
(
    input  logic                            mem_source,
    input  logic                            mem_sink,
    input  logic                            rst_n,
    input  logic [`AVMM_ADDR_WIDTH-1:0]     address,
    input  logic [`AVMM_BURST_WIDTH-1:0]    burstcount,
    input  logic                            read,
    input  logic                            write,
    input  logic [`AVMM_DATA_WIDTH-1:0]     writedata,
    input  logic [`AVMM_DATA_WIDTH/8-1:0]   byteenable,
    output logic                            waitrequest,
    output logic [`AVMM_DATA_WIDTH-1:0]     readdata,
    output logic                            readdatavalid,
    output t_response                       response,
    output t_response                       writeresponse,
    output logic                            writeresponsevalid
);

    localparam int RSP_W = $bits(t_rsp_word) + 1;

    logic                              sink_rst_n;
    logic [$clog2(`AVMM_CMD_DEPTH):0]  cmd_space;
    t_cmd_beat                         src_beat;
    t_cmd_beat                         sink_beat;
    logic                              cmd_push;
    logic                              cmd_valid;
    logic                              cmd_pop;
    logic                              rsp_kind;
    t_rsp_word                         rsp_word;
    logic                              rsp_push;
    logic [RSP_W-1:0]                  rsp_entry;
    logic                              rsp_valid;
    logic                              rsp_pop;
    logic                              credit_return;

    avmm_cmd_decode avmm_cmd_decode_inst (
        .mem_source    (mem_source),
        .rst_n         (rst_n),
        .address       (address),
        .burstcount    (burstcount),
        .read          (read),
        .write         (write),
        .writedata     (writedata),
        .byteenable    (byteenable),
        .space         (cmd_space),
        .credit_return (credit_return),
        .waitrequest   (waitrequest),
        .cmd_beat      (src_beat),
        .cmd_push      (cmd_push)
    );

    // Command path into the sink domain, which also yields the sink reset
    avmm_async_fifo #(
        .WIDTH ($bits(t_cmd_beat)),
        .DEPTH (`AVMM_CMD_DEPTH)
    ) cmd_fifo_inst (
        .wr_clk        (mem_source),
        .wr_rst_n      (rst_n),
        .wr_data       (src_beat),
        .push          (cmd_push),
        .space         (cmd_space),
        .rd_clk        (mem_sink),
        .rd_rst_n      (rst_n),
        .rd_rst_sync_n (sink_rst_n),
        .pop           (cmd_pop),
        .rd_data       (sink_beat),
        .not_empty     (cmd_valid)
    );

    avmm_mem_execute avmm_mem_execute_inst (
        .mem_sink   (mem_sink),
        .sink_rst_n (sink_rst_n),
        .cmd_beat   (sink_beat),
        .cmd_valid  (cmd_valid),
        .cmd_pop    (cmd_pop),
        .rsp_kind   (rsp_kind),
        .rsp_word   (rsp_word),
        .rsp_push   (rsp_push)
    );

    // Response path back to the source; its space is covered by the credits
    avmm_async_fifo #(
        .WIDTH (RSP_W),
        .DEPTH (`AVMM_RSP_DEPTH)
    ) rsp_fifo_inst (
        .wr_clk        (mem_sink),
        .wr_rst_n      (sink_rst_n),
        .wr_data       ({rsp_kind, rsp_word}),
        .push          (rsp_push),
        .space         (),
        .rd_clk        (mem_source),
        .rd_rst_n      (rst_n),
        .rd_rst_sync_n (),
        .pop           (rsp_pop),
        .rd_data       (rsp_entry),
        .not_empty     (rsp_valid)
    );

    avmm_rsp_result avmm_rsp_result_inst (
        .mem_source         (mem_source),
        .rst_n              (rst_n),
        .rsp_kind           (rsp_entry[RSP_W-1]),
        .rsp_word           (rsp_entry[RSP_W-2:0]),
        .rsp_valid          (rsp_valid),
        .rsp_pop            (rsp_pop),
        .readdata           (readdata),
        .readdatavalid      (readdatavalid),
        .response           (response),
        .writeresponse      (writeresponse),
        .writeresponsevalid (writeresponsevalid),
        .credit_return      (credit_return)
    );

endmodule

//--- design/avmm_cfg.svh
// Build-time configuration of the Avalon clock-crossing shim
// Both FIFO depths must be powers of two
// The almost-full threshold must be at least one and well below the command depth
// Bursts are limited to 1 << (AVMM_BURST_WIDTH - 1) beats
`ifndef AVMM_CFG_SVH
`define AVMM_CFG_SVH

// Word address width at the source port
`define AVMM_ADDR_WIDTH 10

// Data width, a whole number of bytes
`define AVMM_DATA_WIDTH 32

// Burstcount width, so bursts run from 1 to 8 beats
`define AVMM_BURST_WIDTH 4

// Command FIFO entries, one beat each
`define AVMM_CMD_DEPTH 16

// Response FIFO entries, which is also the number of response credits
`define AVMM_RSP_DEPTH 32

// Commands that still fit once waitrequest has risen
`define AVMM_ALMFULL_THRESHOLD 2

// Size of the sink memory in words
`define AVMM_MEM_WORDS 256

`endif

//--- design/avmm_cmd_decode.sv
`timescale 1ns/10ps
// Source-side command intake
// A command is accepted only while waitrequest is low; the almost-full margin
// keeps room in the command FIFO for the beats already on their way
// Reads of N beats are expanded into N FIFO beats with waitrequest held high
// The credit check assumes the longest burst, so it stalls slightly early
`include "avmm_cfg.svh"

module avmm_cmd_decode
    import avmm_pkg::*;
(
    input  logic                               mem_source,
    input  logic                               rst_n,
    input  logic [`AVMM_ADDR_WIDTH-1:0]        address,
    input  logic [`AVMM_BURST_WIDTH-1:0]       burstcount,
    input  logic                               read,
    input  logic                               write,
    input  logic [`AVMM_DATA_WIDTH-1:0]        writedata,
    input  logic [`AVMM_DATA_WIDTH/8-1:0]      byteenable,
    input  logic [$clog2(`AVMM_CMD_DEPTH):0]   space,
    input  logic                               credit_return,
    output logic                               waitrequest,
    output t_cmd_beat                          cmd_beat,
    output logic                               cmd_push
);

    localparam int CW        = $clog2(`AVMM_RSP_DEPTH) + 1;
    localparam int SW        = $clog2(`AVMM_CMD_DEPTH) + 1;
    localparam int MAX_BURST = 1 << (`AVMM_BURST_WIDTH - 1);

    logic                          accept_rd;
    logic                          accept_wr;
    logic                          wr_mid;
    logic                          rd_expand;
    logic [`AVMM_BURST_WIDTH-1:0]  wr_left;
    logic [`AVMM_BURST_WIDTH-1:0]  wr_left_next;
    logic [`AVMM_BURST_WIDTH-1:0]  rd_left;
    logic [`AVMM_BURST_WIDTH-1:0]  rd_left_next;
    logic [`AVMM_ADDR_WIDTH-1:0]   wr_addr;
    logic [`AVMM_ADDR_WIDTH-1:0]   rd_addr;
    logic [CW-1:0]                 credits;
    logic [CW-1:0]                 credits_next;
    logic [CW-1:0]                 spend;

    assign accept_rd = read && !waitrequest;
    assign accept_wr = write && !waitrequest;

    // A write burst is in progress while beats remain after the first
    assign wr_mid = (wr_left != '0);

    // Remaining read beats go out one per cycle whenever the FIFO has room
    assign rd_expand = (rd_left != '0) && (space != '0);

    always_comb
    begin
        cmd_beat.is_write   = accept_wr;
        cmd_beat.writedata  = writedata;
        cmd_beat.byteenable = byteenable;
        if (rd_expand)
        begin
            cmd_beat.address = rd_addr;
            cmd_beat.last    = (rd_left == 1);
        end
        else if (accept_wr && wr_mid)
        begin
            // Later beats of a write burst ignore the port address
            cmd_beat.address = wr_addr;
            cmd_beat.last    = (wr_left == 1);
        end
        else
        begin
            cmd_beat.address = address;
            cmd_beat.last    = (burstcount == 1);
        end
    end

    assign cmd_push = accept_rd || accept_wr || rd_expand;

    // Burst counters and the credit balance for the next cycle
    always_comb
    begin
        wr_left_next = wr_left;
        rd_left_next = rd_left;
        spend        = '0;
        if (accept_wr)
        begin
            wr_left_next = wr_mid ? wr_left - 1'b1 : burstcount - 1'b1;
            // The whole write burst gets one response, charged at its first beat
            spend        = wr_mid ? '0 : CW'(1);
        end
        if (accept_rd)
        begin
            rd_left_next = burstcount - 1'b1;
            spend        = CW'(burstcount);
        end
        else if (rd_expand)
        begin
            rd_left_next = rd_left - 1'b1;
        end
        credits_next = credits - spend + CW'(credit_return);
    end

    always_ff @(posedge mem_source)
    begin
        if (!rst_n)
        begin
            waitrequest <= 1'b1;
            wr_left     <= '0;
            rd_left     <= '0;
            credits     <= CW'(`AVMM_RSP_DEPTH);
        end
        else
        begin
            wr_left <= wr_left_next;
            rd_left <= rd_left_next;
            credits <= credits_next;
            // Credits only gate the start of a command, never a running write burst
            waitrequest <= (space <= SW'(`AVMM_ALMFULL_THRESHOLD)) ||
                           (rd_left_next != '0) ||
                           ((wr_left_next == '0) && (credits_next < CW'(MAX_BURST)));
        end
    end

    // Next beat addresses follow the beat just pushed
    always_ff @(posedge mem_source)
    begin
        if (accept_wr)
        begin
            wr_addr <= cmd_beat.address + 1'b1;
        end
        if (accept_rd || rd_expand)
        begin
            rd_addr <= cmd_beat.address + 1'b1;
        end
    end

endmodule

//--- design/avmm_mem_execute.sv
`timescale 1ns/10ps
// Sink-side memory engine, one command beat per mem_sink cycle
// The response FIFO is never checked for space; credits at the source bound it
// Memory content is not cleared by reset
// Beats at or above AVMM_MEM_WORDS are answered with SLVERR and touch nothing
`include "avmm_cfg.svh"

module avmm_mem_execute
    import avmm_pkg::*;
(
    input  logic       mem_sink,
    input  logic       sink_rst_n,
    input  t_cmd_beat  cmd_beat,
    input  logic       cmd_valid,
    output logic       cmd_pop,
    output logic       rsp_kind,
    output t_rsp_word  rsp_word,
    output logic       rsp_push
);

    localparam int MW = $clog2(`AVMM_MEM_WORDS);
    localparam int NB = `AVMM_DATA_WIDTH / 8;

    logic [`AVMM_DATA_WIDTH-1:0] mem [`AVMM_MEM_WORDS];
    logic [`AVMM_DATA_WIDTH-1:0] rd_q;
    logic [MW-1:0]               idx;
    logic                        in_range;
    logic                        burst_err;
    logic                        s_valid;
    logic                        s_is_write;
    logic                        s_last;
    t_response                   s_resp;

    // Every beat is consumed in the cycle it appears
    assign cmd_pop = cmd_valid;

    assign idx      = cmd_beat.address[MW-1:0];
    assign in_range = (cmd_beat.address < `AVMM_ADDR_WIDTH'(`AVMM_MEM_WORDS));

    // Byte-masked writes and a registered read port
    always_ff @(posedge mem_sink)
    begin
        if (cmd_valid && in_range)
        begin
            if (cmd_beat.is_write)
            begin
                for (int b = 0; b < NB; b++)
                begin
                    if (cmd_beat.byteenable[b])
                    begin
                        mem[idx][b*8 +: 8] <= cmd_beat.writedata[b*8 +: 8];
                    end
                end
            end
            else
            begin
                rd_q <= mem[idx];
            end
        end
    end

    always_ff @(posedge mem_sink)
    begin
        if (!sink_rst_n)
        begin
            s_valid   <= 1'b0;
            burst_err <= 1'b0;
        end
        else
        begin
            s_valid <= cmd_valid;
            // Error flag collects across a write burst and clears at its last beat
            if (cmd_valid && cmd_beat.is_write)
            begin
                burst_err <= !cmd_beat.last && (burst_err || !in_range);
            end
        end
    end

    // Beat attributes travel alongside the memory read stage
    always_ff @(posedge mem_sink)
    begin
        if (cmd_valid)
        begin
            s_is_write <= cmd_beat.is_write;
            s_last     <= cmd_beat.last;
            s_resp     <= (!in_range || (cmd_beat.is_write && burst_err)) ? SLVERR : OKAY;
        end
    end

    // Reads answer every beat, writes only at the end of the burst
    assign rsp_push = s_valid && (!s_is_write || s_last);
    assign rsp_kind = s_is_write;

    always_comb
    begin
        rsp_word = '0;
        if (s_is_write)
        begin
            rsp_word.wr.response = s_resp;
            rsp_word.wr.last     = s_last;
        end
        else
        begin
            rsp_word.rd.response = s_resp;
            // Out-of-range reads return zero rather than a stale word
            rsp_word.rd.data     = (s_resp == OKAY) ? rd_q : '0;
        end
    end

endmodule

//--- design/avmm_pkg.sv
// Types shared by the shim blocks
// Response codes use the Avalon encoding, and only OKAY and SLVERR are produced
// A response FIFO word is decoded as read or write view by a kind bit kept beside it
`include "avmm_cfg.svh"

package avmm_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } t_response;

    // One command FIFO entry, always a single beat with its own address
    typedef struct packed {
        logic                            is_write;
        logic [`AVMM_ADDR_WIDTH-1:0]     address;
        logic [`AVMM_DATA_WIDTH-1:0]     writedata;
        logic [`AVMM_DATA_WIDTH/8-1:0]   byteenable;
        logic                            last;
    } t_cmd_beat;

    // Read view carries the returned word
    typedef struct packed {
        t_response                   response;
        logic [`AVMM_DATA_WIDTH-1:0] data;
    } t_rsp_rd;

    // Write view has no data, only the burst status and its closing flag
    typedef struct packed {
        t_response                   response;
        logic [`AVMM_DATA_WIDTH-2:0] pad;
        logic                        last;
    } t_rsp_wr;

    typedef union packed {
        t_rsp_rd rd;
        t_rsp_wr wr;
    } t_rsp_word;

endpackage

//--- design/avmm_rsp_result.sv
`timescale 1ns/10ps
// Source-side response delivery, one word per mem_source cycle
// A kind bit of one selects the write view of the word, zero the read view
// Each popped word returns one credit to the decode block a cycle later
`include "avmm_cfg.svh"

module avmm_rsp_result
    import avmm_pkg::*;
(
    input  logic                          mem_source,
    input  logic                          rst_n,
    input  logic                          rsp_kind,
    input  t_rsp_word                     rsp_word,
    input  logic                          rsp_valid,
    output logic                          rsp_pop,
    output logic [`AVMM_DATA_WIDTH-1:0]   readdata,
    output logic                          readdatavalid,
    output t_response                     response,
    output t_response                     writeresponse,
    output logic                          writeresponsevalid,
    output logic                          credit_return
);

    // The head word is always taken when present
    assign rsp_pop = rsp_valid;

    always_ff @(posedge mem_source)
    begin
        if (!rst_n)
        begin
            readdatavalid      <= 1'b0;
            writeresponsevalid <= 1'b0;
            credit_return      <= 1'b0;
        end
        else
        begin
            readdatavalid      <= rsp_valid && !rsp_kind;
            writeresponsevalid <= rsp_valid && rsp_kind;
            credit_return      <= rsp_valid;
        end
    end

    // Payloads hold their last value between valid cycles
    always_ff @(posedge mem_source)
    begin
        if (rsp_valid && !rsp_kind)
        begin
            readdata <= rsp_word.rd.data;
            response <= rsp_word.rd.response;
        end
        if (rsp_valid && rsp_kind)
        begin
            writeresponse <= rsp_word.wr.response;
        end
    end

endmodule

//--- project.f
+incdir+design
design/avmm_pkg.sv
design/avmm_async_fifo.sv
design/avmm_cmd_decode.sv
design/avmm_mem_execute.sv
design/avmm_rsp_result.sv
design/avmm_async_shim_top.sv
testbench/avmm_shim_chk.sv
testbench/avmm_shim_tb.sv

//--- testbench/avmm_shim_chk.sv
`timescale 1ns/10ps
// Protocol checks on the shim source port, bound into the top level
// The reset rule is checked from the second clock of reset on, once the
// registered outputs have taken their reset values
module avmm_shim_chk (
    input logic mem_source,
    input logic rst_n,
    input logic read,
    input logic write,
    input logic waitrequest,
    input logic readdatavalid,
    input logic writeresponsevalid
);

    int   valid_fails = 0;
    int   reset_fails = 0;
    int   cmd_fails   = 0;
    int   fail_count;
    logic rst_held;

    // High when rst_n was already low at the previous clock
    always_ff @(posedge mem_source)
    begin
        rst_held <= !rst_n;
    end

    assign fail_count = valid_fails + reset_fails + cmd_fails;

    // Read data and write responses share one return slot per cycle
    one_valid: assert property (@(posedge mem_source) disable iff (!rst_n)
        !(readdatavalid && writeresponsevalid))
    else
    begin
        $error("readdatavalid and writeresponsevalid are high in the same cycle");
        valid_fails++;
    end

    // Port stays stalled and silent for the whole reset
    reset_state: assert property (@(posedge mem_source)
        (!rst_n && rst_held) |-> (waitrequest && !readdatavalid && !writeresponsevalid))
    else
    begin
        $error("Port outputs are not in their reset state while rst_n is low");
        reset_fails++;
    end

    // The source never asks for a read and a write at once
    one_command: assert property (@(posedge mem_source) !(read && write))
    else
    begin
        $error("read and write are driven high together");
        cmd_fails++;
    end

endmodule

bind avmm_async_shim_top avmm_shim_chk avmm_shim_chk_inst (
    .mem_source         (mem_source),
    .rst_n              (rst_n),
    .read               (read),
    .write              (write),
    .waitrequest        (waitrequest),
    .readdatavalid      (readdatavalid),
    .writeresponsevalid (writeresponsevalid)
);

//--- testbench/avmm_shim_tb.sv
`timescale 1ns/10ps
// Directed testbench for the Avalon clock-crossing shim
// Inputs change on the falling edge of mem_source and outputs are sampled there
// Responses are compared in issue order against a word-level memory model
// Only addresses written earlier in the run are ever read back
`include "avmm_cfg.svh"

module avmm_shim_tb
    import avmm_pkg::*;
();

    localparam int MEM_WORDS  = `AVMM_MEM_WORDS;
    localparam int NB         = `AVMM_DATA_WIDTH / 8;
    localparam int EW         = `AVMM_DATA_WIDTH + 3;
    localparam int WAIT_LIMIT = 200;
    localparam int RESP_LIMIT = 600;

    logic                            mem_source;
    logic                            mem_sink;
    logic                            rst_n;
    logic [`AVMM_ADDR_WIDTH-1:0]     address;
    logic [`AVMM_BURST_WIDTH-1:0]    burstcount;
    logic                            read;
    logic                            write;
    logic [`AVMM_DATA_WIDTH-1:0]     writedata;
    logic [NB-1:0]                   byteenable;
    logic                            waitrequest;
    logic [`AVMM_DATA_WIDTH-1:0]     readdata;
    logic                            readdatavalid;
    t_response                       response;
    t_response                       writeresponse;
    logic                            writeresponsevalid;

    // Memory model and the data of the next write burst
    logic [`AVMM_DATA_WIDTH-1:0]     model_mem [MEM_WORDS];
    logic [`AVMM_DATA_WIDTH-1:0]     wdata_buf [8];

    // Entries are {kind, response, data}; kind is one for a write response
    logic [EW-1:0]                   exp_q [$];
    logic [EW-1:0]                   obs_q [$];

    int                              error_count   = 0;
    int                              timeout_count = 0;
    int                              assert_fails;

    avmm_async_shim_top avmm_async_shim_top_inst (
        .mem_source         (mem_source),
        .mem_sink           (mem_sink),
        .rst_n              (rst_n),
        .address            (address),
        .burstcount         (burstcount),
        .read               (read),
        .write              (write),
        .writedata          (writedata),
        .byteenable         (byteenable),
        .waitrequest        (waitrequest),
        .readdata           (readdata),
        .readdatavalid      (readdatavalid),
        .response           (response),
        .writeresponse      (writeresponse),
        .writeresponsevalid (writeresponsevalid)
    );

    initial
    begin
        mem_source = 1'b0;
        mem_sink   = 1'b0;
    end

    always #50 mem_source = ~mem_source;

    // Sink clock runs at a 70 ns period with no fixed phase to the source
    always #35 mem_sink = ~mem_sink;

    // Collect every response the port returns, in arrival order
    always @(negedge mem_source)
    begin
        if (readdatavalid === 1'b1)
        begin
            obs_q.push_back({1'b0, response, readdata});
        end
        if (writeresponsevalid === 1'b1)
        begin
            obs_q.push_back({1'b1, writeresponse, `AVMM_DATA_WIDTH'(0)});
        end
    end

    // Expected read response for one beat address
    function automatic logic [EW-1:0] read_expect(input logic [`AVMM_ADDR_WIDTH-1:0] a);
        if (a < MEM_WORDS)
        begin
            return {1'b0, OKAY, model_mem[a[7:0]]};
        end
        return {1'b0, SLVERR, `AVMM_DATA_WIDTH'(0)};
    endfunction

    // Waits until waitrequest is low at a falling edge
    task automatic wait_ready();
        int n;
        n = 0;
        while (waitrequest !== 1'b0 && n < WAIT_LIMIT)
        begin
            @(negedge mem_source);
            n++;
        end
        if (waitrequest !== 1'b0)
        begin
            $display("Timeout: waitrequest stayed high for %0d cycles at %0t", n, $time);
            timeout_count++;
        end
    endtask

    // Issues a read burst as one command and books its expected beats
    task automatic read_burst(input logic [`AVMM_ADDR_WIDTH-1:0] addr, input int len);
        wait_ready();
        address    = addr;
        burstcount = `AVMM_BURST_WIDTH'(len);
        read       = 1'b1;
        @(negedge mem_source);
        read = 1'b0;
        for (int i = 0; i < len; i++)
        begin
            exp_q.push_back(read_expect(addr + `AVMM_ADDR_WIDTH'(i)));
        end
    endtask

    // Writes wdata_buf one beat per accepted cycle and updates the model
    task automatic write_burst(input logic [`AVMM_ADDR_WIDTH-1:0] addr, input int len,
                               input logic [NB-1:0] be);
        logic [`AVMM_ADDR_WIDTH-1:0] a;
        logic                        err;
        t_response                   r;
        err = 1'b0;
        for (int i = 0; i < len; i++)
        begin
            // Drop the beat while the port stalls
            if (waitrequest !== 1'b0)
            begin
                write = 1'b0;
            end
            wait_ready();
            a          = addr + `AVMM_ADDR_WIDTH'(i);
            address    = a;
            burstcount = `AVMM_BURST_WIDTH'(len);
            writedata  = wdata_buf[i];
            byteenable = be;
            write      = 1'b1;
            @(negedge mem_source);
            if (a < MEM_WORDS)
            begin
                for (int b = 0; b < NB; b++)
                begin
                    if (be[b])
                    begin
                        model_mem[a[7:0]][b*8 +: 8] = wdata_buf[i][b*8 +: 8];
                    end
                end
            end
            else
            begin
                err = 1'b1;
            end
        end
        write = 1'b0;
        r = err ? SLVERR : OKAY;
        exp_q.push_back({1'b1, r, `AVMM_DATA_WIDTH'(0)});
    endtask

    // Waits for every booked response and compares them in order
    task automatic drain_responses(input string name);
        int            n;
        logic [EW-1:0] e;
        logic [EW-1:0] o;
        n = 0;
        while (obs_q.size() < exp_q.size() && n < RESP_LIMIT)
        begin
            @(negedge mem_source);
            n++;
        end
        if (obs_q.size() < exp_q.size())
        begin
            $display("Timeout in %s: only %0d of %0d responses arrived", name,
                     obs_q.size(), exp_q.size());
            timeout_count++;
        end
        while (exp_q.size() != 0 && obs_q.size() != 0)
        begin
            e = exp_q.pop_front();
            o = obs_q.pop_front();
            if (o !== e)
            begin
                $display("ERROR at %0t: %s expected kind %0b resp %0d data %h, got %0b %0d %h",
                         $time, name, e[EW-1], e[EW-2:EW-3], e[EW-4:0],
                         o[EW-1], o[EW-2:EW-3], o[EW-4:0]);
                error_count++;
            end
        end
        exp_q.delete();
    endtask

    // Reset values hold for 16 cycles and the port opens once rst_n is released
    task automatic test_reset();
        for (int c = 0; c < 16; c++)
        begin
            @(negedge mem_source);
            if (waitrequest !== 1'b1 || readdatavalid !== 1'b0 || writeresponsevalid !== 1'b0)
            begin
                $display("ERROR at %0t: port outputs not in reset state", $time);
                error_count++;
            end
        end
        rst_n = 1'b1;
        wait_ready();
    endtask

    // Full word write, partial overwrite, then one read of the merged word
    task automatic test_single();
        logic [`AVMM_ADDR_WIDTH-1:0] a;
        a            = `AVMM_ADDR_WIDTH'($urandom % MEM_WORDS);
        wdata_buf[0] = $urandom;
        write_burst(a, 1, 4'hf);
        wdata_buf[0] = $urandom;
        write_burst(a, 1, 4'b0110);
        read_burst(a, 1);
        drain_responses("single write and read");
    endtask

    // Eight-beat write burst read back by an eight-beat read burst
    task automatic test_bursts();
        logic [`AVMM_ADDR_WIDTH-1:0] a;
        a = `AVMM_ADDR_WIDTH'($urandom % (MEM_WORDS - 8));
        for (int i = 0; i < 8; i++)
        begin
            wdata_buf[i] = $urandom;
        end
        write_burst(a, 8, 4'hf);
        read_burst(a, 8);
        drain_responses("bursts");
    endtask

    // Beats past the end of memory answer SLVERR and leave memory alone
    task automatic test_out_of_range();
        wdata_buf[0] = $urandom;
        write_burst(`AVMM_ADDR_WIDTH'(0), 1, 4'hf);
        wdata_buf[0] = $urandom;
        wdata_buf[1] = $urandom;
        read_burst(`AVMM_ADDR_WIDTH'(300), 1);
        write_burst(`AVMM_ADDR_WIDTH'(MEM_WORDS - 1), 2, 4'hf);
        read_burst(`AVMM_ADDR_WIDTH'(MEM_WORDS - 1), 1);
        // Word 0 shares its low address bits with the dropped beat at 256
        read_burst(`AVMM_ADDR_WIDTH'(0), 1);
        drain_responses("out of range");
    endtask

    // A block of words is filled first, then 40 single reads run back to back
    task automatic test_back_pressure();
        for (int blk = 0; blk < 8; blk++)
        begin
            for (int i = 0; i < 8; i++)
            begin
                wdata_buf[i] = $urandom;
            end
            write_burst(`AVMM_ADDR_WIDTH'(64 + blk * 8), 8, 4'hf);
        end
        drain_responses("back-pressure fill");
        for (int k = 0; k < 40; k++)
        begin
            read_burst(`AVMM_ADDR_WIDTH'(64 + ($urandom % 64)), 1);
        end
        drain_responses("back-pressure reads");
    endtask

    initial
    begin
        void'($urandom(75));
        rst_n      = 1'b0;
        address    = '0;
        burstcount = `AVMM_BURST_WIDTH'(1);
        read       = 1'b0;
        write      = 1'b0;
        writedata  = '0;
        byteenable = '0;

        test_reset();
        test_single();
        test_bursts();
        test_out_of_range();
        test_back_pressure();

        // Nothing more may arrive once every test has drained
        repeat (20) @(negedge mem_source);
        if (obs_q.size() != 0)
        begin
            $display("ERROR at %0t: %0d unexpected responses arrived", $time, obs_q.size());
            error_count++;
        end

        assert_fails = avmm_async_shim_top_inst.avmm_shim_chk_inst.fail_count;
        $display("Run complete: %0d check errors, %0d timeouts, %0d assertion failures",
                 error_count, timeout_count, assert_fails);
        if (error_count == 0 && timeout_count == 0 && assert_fails == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
